//--- source/mm_pkg.sv
package mm_pkg;

    // matrix geometry
    localparam int dim = 64;
    localparam int idx_w = 6;

    // sweep counter is {i, j, k}, k in the low bits
    localparam int cnt_w = 3 * idx_w;
    localparam int sweep_len = 1 << cnt_w;

    // data path widths
    localparam int elem_w = 8;
    localparam int prod_w = 2 * elem_w;

    // 64 products of 16 bits need 6 more bits
    localparam int acc_w = prod_w + idx_w;

endpackage

//--- source/mem_pkg.sv
package mem_pkg;

    // memory geometry
    localparam int addr_w = 12;
    localparam int row_w = 10;
    localparam int col_w = 2;
    localparam int mem_words = 1 << addr_w;

    // host memory select codes
    localparam logic [1:0] sel_a = 2'd0;
    localparam logic [1:0] sel_b = 2'd1;
    localparam logic [1:0] sel_c = 2'd2;

    // row and column as the memory macro sees them
    typedef struct packed {
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
    } mem_split_t;

    // flat element index or row/col split, same 12 bits
    typedef union packed {
        logic [addr_w-1:0] flat;
        mem_split_t split;
    } mem_addr_t;

endpackage

//--- source/mux4_sram.sv
`timescale 1ns/100ps

module mux4_sram #(
    parameter int data_w = 8
) (
    input  logic                clk,
    input  logic                en,
    input  logic                we,
    input  mem_pkg::mem_addr_t  addr,
    input  logic [data_w-1:0]   wdata,
    output logic [data_w-1:0]   rdata
);

    // each row holds four words, col picks one of them
    logic [(1 << mem_pkg::col_w)-1:0][data_w-1:0] mem [mem_pkg::mem_words >> mem_pkg::col_w];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr.split.row][addr.split.col] <= wdata;
            end else begin
                // one cycle read latency
                rdata <= mem[addr.split.row][addr.split.col];
            end
        end
    end

endmodule

//--- source/mm_sequencer.sv
`timescale 1ns/100ps

module mm_sequencer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        start,
    output logic                        busy,
    output logic                        done,
    output logic                        eng_rd,
    output logic [mem_pkg::addr_w-1:0]  eng_addr_a,
    output logic [mem_pkg::addr_w-1:0]  eng_addr_b,
    output logic [mem_pkg::addr_w-1:0]  eng_addr_c,
    output logic                        mac_valid,
    output logic                        mac_first,
    output logic                        mac_last
);

    logic [mm_pkg::cnt_w-1:0]   cnt;
    logic                       issuing;
    logic                       sweep_end;
    logic [mm_pkg::idx_w-1:0]   idx_i;
    logic [mm_pkg::idx_w-1:0]   idx_j;
    logic [mm_pkg::idx_w-1:0]   idx_k;
    logic [mem_pkg::addr_w-1:0] addr_c_d1;
    // read, accumulate and write stages after the last issue
    logic [2:0]                 tail;

    assign idx_i = cnt[3*mm_pkg::idx_w-1:2*mm_pkg::idx_w];
    assign idx_j = cnt[2*mm_pkg::idx_w-1:mm_pkg::idx_w];
    assign idx_k = cnt[mm_pkg::idx_w-1:0];

    // A walks a row, B walks a column
    assign eng_addr_a = {idx_i, idx_k};
    assign eng_addr_b = {idx_k, idx_j};
    assign eng_rd = issuing;

    assign sweep_end = issuing && (cnt == mm_pkg::cnt_w'(mm_pkg::sweep_len - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            done <= 1'b0;
            issuing <= 1'b0;
            cnt <= '0;
            tail <= '0;
        end else begin
            done <= 1'b0;
            tail <= {tail[1:0], sweep_end};
            if (!busy && start) begin
                busy <= 1'b1;
                issuing <= 1'b1;
                cnt <= '0;
            end else if (tail[2]) begin
                // last C word has been written
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (issuing) begin
                cnt <= cnt + 1'b1;
                if (sweep_end) begin
                    issuing <= 1'b0;
                end
            end
        end
    end

    // flags line up with the memory read data
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mac_valid <= 1'b0;
            mac_first <= 1'b0;
            mac_last <= 1'b0;
        end else begin
            mac_valid <= eng_rd;
            mac_first <= eng_rd && (idx_k == 0);
            mac_last <= eng_rd && (idx_k == mm_pkg::dim - 1);
        end
    end

    // C address follows two stages behind, to meet the MAC result
    always_ff @(posedge clk) begin
        addr_c_d1 <= {idx_i, idx_j};
        eng_addr_c <= addr_c_d1;
    end

endmodule

//--- source/mac_unit.sv
`timescale 1ns/100ps

module mac_unit (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [mm_pkg::elem_w-1:0]   a,
    input  logic [mm_pkg::elem_w-1:0]   b,
    input  logic                        valid,
    input  logic                        first,
    input  logic                        last,
    output logic [mm_pkg::acc_w-1:0]    result,
    output logic                        result_valid
);

    logic [mm_pkg::prod_w-1:0] prod;
    logic [mm_pkg::acc_w-1:0]  acc;
    logic [mm_pkg::acc_w-1:0]  sum;

    assign prod = a * b;

    // first term restarts the sum
    assign sum = (first ? '0 : acc) + mm_pkg::acc_w'(prod);

    always_ff @(posedge clk) begin
        if (valid) begin
            acc <= sum;
            // hold the finished element while the next one accumulates
            if (last) begin
                result <= sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid && last;
        end
    end

endmodule

//--- source/mem_port_arbiter.sv
`timescale 1ns/100ps

module mem_port_arbiter (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        busy,
    input  logic                        host_en,
    input  logic                        host_we,
    input  logic [1:0]                  host_sel,
    input  logic [mem_pkg::addr_w-1:0]  host_addr,
    input  logic [mm_pkg::elem_w-1:0]   host_wdata,
    output logic [mm_pkg::acc_w-1:0]    host_rdata,
    input  logic                        eng_rd,
    input  logic [mem_pkg::addr_w-1:0]  eng_addr_a,
    input  logic [mem_pkg::addr_w-1:0]  eng_addr_b,
    input  logic [mem_pkg::addr_w-1:0]  eng_addr_c,
    input  logic [mm_pkg::acc_w-1:0]    c_wdata,
    input  logic                        c_we,
    output logic                        a_en,
    output logic                        a_we,
    output mem_pkg::mem_addr_t          a_addr,
    output logic [mm_pkg::elem_w-1:0]   a_wdata,
    output logic                        b_en,
    output logic                        b_we,
    output mem_pkg::mem_addr_t          b_addr,
    output logic [mm_pkg::elem_w-1:0]   b_wdata,
    output logic                        c_en,
    output logic                        c_we_mem,
    output mem_pkg::mem_addr_t          c_addr,
    output logic [mm_pkg::acc_w-1:0]    c_wdata_mem,
    input  logic [mm_pkg::elem_w-1:0]   a_rdata,
    input  logic [mm_pkg::elem_w-1:0]   b_rdata,
    input  logic [mm_pkg::acc_w-1:0]    c_rdata
);

    logic       host_a;
    logic       host_b;
    logic       host_c;
    logic [1:0] sel_q;

    assign host_a = host_en && (host_sel == mem_pkg::sel_a);
    assign host_b = host_en && (host_sel == mem_pkg::sel_b);
    assign host_c = host_en && (host_sel == mem_pkg::sel_c);

    always_comb begin
        if (busy) begin
            // engine owns every port
            a_en = eng_rd;
            a_we = 1'b0;
            a_addr.flat = eng_addr_a;
            a_wdata = '0;
            b_en = eng_rd;
            b_we = 1'b0;
            b_addr.flat = eng_addr_b;
            b_wdata = '0;
            c_en = c_we;
            c_we_mem = c_we;
            c_addr.flat = eng_addr_c;
            c_wdata_mem = c_wdata;
        end else begin
            a_en = host_a;
            a_we = host_a && host_we;
            a_addr.flat = host_addr;
            a_wdata = host_wdata;
            b_en = host_b;
            b_we = host_b && host_we;
            b_addr.flat = host_addr;
            b_wdata = host_wdata;
            // C is read only from the host side
            c_en = host_c && !host_we;
            c_we_mem = 1'b0;
            c_addr.flat = host_addr;
            c_wdata_mem = '0;
        end
    end

    // remember which memory the pending read went to
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sel_q <= mem_pkg::sel_a;
        end else if (host_en && !busy) begin
            sel_q <= host_sel;
        end
    end

    always_comb begin
        case (sel_q)
            mem_pkg::sel_a: host_rdata = mm_pkg::acc_w'(a_rdata);
            mem_pkg::sel_b: host_rdata = mm_pkg::acc_w'(b_rdata);
            mem_pkg::sel_c: host_rdata = c_rdata;
            default:        host_rdata = '0;
        endcase
    end

endmodule

//--- source/mat_mult_top.sv
`timescale 1ns/100ps

module mat_mult_top (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        start,
    output logic                        busy,
    output logic                        done,
    input  logic                        host_en,
    input  logic                        host_we,
    input  logic [1:0]                  host_sel,
    input  logic [mem_pkg::addr_w-1:0]  host_addr,
    input  logic [mm_pkg::elem_w-1:0]   host_wdata,
    output logic [mm_pkg::acc_w-1:0]    host_rdata
);

    // engine side
    logic                        eng_rd;
    logic [mem_pkg::addr_w-1:0]  eng_addr_a;
    logic [mem_pkg::addr_w-1:0]  eng_addr_b;
    logic [mem_pkg::addr_w-1:0]  eng_addr_c;
    logic                        mac_valid;
    logic                        mac_first;
    logic                        mac_last;
    logic [mm_pkg::acc_w-1:0]    mac_result;
    logic                        mac_result_valid;

    // memory side
    logic                        a_en;
    logic                        a_we;
    mem_pkg::mem_addr_t          a_addr;
    logic [mm_pkg::elem_w-1:0]   a_wdata;
    logic [mm_pkg::elem_w-1:0]   a_rdata;
    logic                        b_en;
    logic                        b_we;
    mem_pkg::mem_addr_t          b_addr;
    logic [mm_pkg::elem_w-1:0]   b_wdata;
    logic [mm_pkg::elem_w-1:0]   b_rdata;
    logic                        c_en;
    logic                        c_we_mem;
    mem_pkg::mem_addr_t          c_addr;
    logic [mm_pkg::acc_w-1:0]    c_wdata_mem;
    logic [mm_pkg::acc_w-1:0]    c_rdata;

    mm_sequencer u_seq (
        .clk(clk), .rstn(rstn), .start(start), .busy(busy), .done(done),
        .eng_rd(eng_rd), .eng_addr_a(eng_addr_a), .eng_addr_b(eng_addr_b),
        .eng_addr_c(eng_addr_c), .mac_valid(mac_valid), .mac_first(mac_first),
        .mac_last(mac_last)
    );

    mac_unit u_mac (
        .clk(clk), .rstn(rstn), .a(a_rdata), .b(b_rdata), .valid(mac_valid),
        .first(mac_first), .last(mac_last), .result(mac_result),
        .result_valid(mac_result_valid)
    );

    mem_port_arbiter u_arb (
        .clk(clk), .rstn(rstn), .busy(busy),
        .host_en(host_en), .host_we(host_we), .host_sel(host_sel),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
        .eng_rd(eng_rd), .eng_addr_a(eng_addr_a), .eng_addr_b(eng_addr_b),
        .eng_addr_c(eng_addr_c), .c_wdata(mac_result), .c_we(mac_result_valid),
        .a_en(a_en), .a_we(a_we), .a_addr(a_addr), .a_wdata(a_wdata),
        .b_en(b_en), .b_we(b_we), .b_addr(b_addr), .b_wdata(b_wdata),
        .c_en(c_en), .c_we_mem(c_we_mem), .c_addr(c_addr), .c_wdata_mem(c_wdata_mem),
        .a_rdata(a_rdata), .b_rdata(b_rdata), .c_rdata(c_rdata)
    );

    mux4_sram #(.data_w(mm_pkg::elem_w)) mem_a (
        .clk(clk), .en(a_en), .we(a_we), .addr(a_addr), .wdata(a_wdata), .rdata(a_rdata)
    );

    mux4_sram #(.data_w(mm_pkg::elem_w)) mem_b (
        .clk(clk), .en(b_en), .we(b_we), .addr(b_addr), .wdata(b_wdata), .rdata(b_rdata)
    );

    mux4_sram #(.data_w(mm_pkg::acc_w)) mem_c (
        .clk(clk), .en(c_en), .we(c_we_mem), .addr(c_addr), .wdata(c_wdata_mem),
        .rdata(c_rdata)
    );

endmodule

//--- sim/tb_mat_mult.sv
`timescale 1ns/100ps

module tb_mat_mult;

    localparam int clk_period = 20;
    localparam int drive_dly = 2;
    localparam int words = mem_pkg::mem_words;
    localparam int run_cycles = mm_pkg::sweep_len + 3;
    // three loads, readbacks, two runs and some slack
    localparam int budget_cycles = 6 * words + 2 * run_cycles + 2000;

    logic                       clk;
    logic                       rstn;
    logic                       start;
    logic                       busy;
    logic                       done;
    logic                       host_en;
    logic                       host_we;
    logic [1:0]                 host_sel;
    logic [mem_pkg::addr_w-1:0] host_addr;
    logic [mm_pkg::elem_w-1:0]  host_wdata;
    logic [mm_pkg::acc_w-1:0]   host_rdata;

    // testbench copies of A and B
    logic [mm_pkg::elem_w-1:0]  a_ref [words];
    logic [mm_pkg::elem_w-1:0]  b_ref [words];
    integer                     seed = 32'hf823;

    // expected data of the read being driven
    logic [mm_pkg::acc_w-1:0]   rd_exp;
    string                      rd_name;
    int                         n_reads = 0;
    int                         n_checks = 0;

    // read waiting for its data in the compare process
    bit                         rd_pending = 1'b0;
    logic [mm_pkg::acc_w-1:0]   pend_exp;
    string                      pend_name;
    logic [mem_pkg::addr_w-1:0] pend_addr;

    mat_mult_top UUT (
        .clk(clk), .rstn(rstn), .start(start), .busy(busy), .done(done),
        .host_en(host_en), .host_we(host_we), .host_sel(host_sel),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    initial begin
        #(2 * budget_cycles * clk_period);
        stop_on_error("watchdog expired, the run hung without reaching its end");
    end

    // sum over k of A(i,k) * B(k,j)
    function automatic logic [mm_pkg::acc_w-1:0] ref_elem(input int i, input int j);
        logic [mm_pkg::acc_w-1:0] sum;
        int k;
        sum = '0;
        for (k = 0; k < mm_pkg::dim; k++) begin
            sum = sum + mm_pkg::acc_w'(a_ref[i * mm_pkg::dim + k])
                      * mm_pkg::acc_w'(b_ref[k * mm_pkg::dim + j]);
        end
        return sum;
    endfunction

    function automatic logic [mem_pkg::addr_w-1:0] blocked_addr(input int n);
        return mem_pkg::addr_w'((n * 509 + 7) % words);
    endfunction

    task automatic step();
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic host_write(input logic [1:0] sel, input int addr,
                              input logic [mm_pkg::elem_w-1:0] data);
        host_en = 1'b1;
        host_we = 1'b1;
        host_sel = sel;
        host_addr = mem_pkg::addr_w'(addr);
        host_wdata = data;
        step();
    endtask

    task automatic host_read(input logic [1:0] sel, input int addr,
                             input logic [mm_pkg::acc_w-1:0] exp, input string name);
        host_en = 1'b1;
        host_we = 1'b0;
        host_sel = sel;
        host_addr = mem_pkg::addr_w'(addr);
        rd_exp = exp;
        rd_name = name;
        n_reads++;
        step();
    endtask

    // two idle cycles let the last read reach the compare process
    task automatic host_idle();
        host_en = 1'b0;
        host_we = 1'b0;
        step();
        step();
    endtask

    task automatic load_matrix(input logic [1:0] sel);
        int n;
        for (n = 0; n < words; n++) begin
            host_write(sel, n, (sel == mem_pkg::sel_a) ? a_ref[n] : b_ref[n]);
        end
        host_idle();
    endtask

    task automatic check_c(input string name, input bit identity);
        int n;
        logic [mm_pkg::acc_w-1:0] exp;
        for (n = 0; n < words; n++) begin
            if (identity) begin
                exp = mm_pkg::acc_w'(a_ref[n]);
            end else begin
                exp = ref_elem(n / mm_pkg::dim, n % mm_pkg::dim);
            end
            host_read(mem_pkg::sel_c, n, exp, name);
        end
        host_idle();
    endtask

    // start pulse, then count cycles until done; optionally poke the
    // engine with a second start and host writes to A while busy
    task automatic run_engine(input string name, input bit blocking);
        int cycles;
        start = 1'b1;
        step();
        start = 1'b0;
        assert (busy) else
            stop_on_error($sformatf("[ERROR] %s: expected busy 1, actual %0b", name, busy));
        cycles = 0;
        do begin
            if (blocking && cycles >= 50 && cycles < 58) begin
                start = (cycles == 50) || (cycles == 54);
                host_en = 1'b1;
                host_we = 1'b1;
                host_sel = mem_pkg::sel_a;
                host_addr = blocked_addr(cycles - 50);
                host_wdata = ~a_ref[host_addr];
            end else begin
                start = 1'b0;
                host_en = 1'b0;
                host_we = 1'b0;
            end
            step();
            cycles++;
            if (!done) begin
                assert (busy) else
                    stop_on_error($sformatf("%s: busy dropped before done", name));
            end
        end while (!done);
        assert (cycles == run_cycles) else
            stop_on_error($sformatf("[ERROR] %s: expected done after %0d cycles, actual %0d",
                                    name, run_cycles, cycles));
        assert (!busy) else
            stop_on_error($sformatf("[ERROR] %s: expected busy 0 with done, actual %0b",
                                    name, busy));
        step();
        assert (!done) else
            stop_on_error($sformatf("%s: done stayed high for more than one cycle", name));
    endtask

    // read data shows up one cycle after the read strobe
    always @(negedge clk) begin
        if (rd_pending) begin
            n_checks++;
            assert (host_rdata == pend_exp) else
                stop_on_error($sformatf("[ERROR] %s: addr %0d expected %0h, actual %0h",
                                        pend_name, pend_addr, pend_exp, host_rdata));
        end
        rd_pending = host_en && !host_we && !busy;
        pend_exp = rd_exp;
        pend_name = rd_name;
        pend_addr = host_addr;
    end

    initial begin
        int n;
        int addr;
        rstn = 1'b0;
        start = 1'b0;
        host_en = 1'b0;
        host_we = 1'b0;
        host_sel = mem_pkg::sel_a;
        host_addr = '0;
        host_wdata = '0;
        rd_exp = '0;
        rd_name = "none";
        repeat (8) step();
        rstn = 1'b1;
        step();
        assert (!busy && !done) else
            stop_on_error($sformatf("[ERROR] reset_state: expected busy 0 done 0, actual %0b %0b",
                                    busy, done));

        for (n = 0; n < words; n++) begin
            a_ref[n] = mm_pkg::elem_w'($random(seed));
            b_ref[n] = mm_pkg::elem_w'($random(seed));
        end
        load_matrix(mem_pkg::sel_a);
        load_matrix(mem_pkg::sel_b);
        for (n = 0; n < 16; n++) begin
            addr = (n * 257 + 11) % words;
            host_read(mem_pkg::sel_a, addr, mm_pkg::acc_w'(a_ref[addr]), "a_readback");
            host_read(mem_pkg::sel_b, addr, mm_pkg::acc_w'(b_ref[addr]), "b_readback");
        end
        host_idle();

        run_engine("random_run", 1'b1);
        // writes issued while busy must not have landed
        for (n = 0; n < 8; n++) begin
            addr = int'(blocked_addr(n));
            host_read(mem_pkg::sel_a, addr, mm_pkg::acc_w'(a_ref[addr]), "blocked_write");
        end
        host_idle();
        check_c("random_run", 1'b0);

        for (n = 0; n < 4; n++) begin
            host_write(mem_pkg::sel_c, n * 1000 + 3, 8'h5a);
        end
        for (n = 0; n < 4; n++) begin
            addr = n * 1000 + 3;
            host_read(mem_pkg::sel_c, addr, ref_elem(addr / mm_pkg::dim, addr % mm_pkg::dim),
                      "c_write_ignored");
        end
        host_idle();

        for (n = 0; n < words; n++) begin
            b_ref[n] = (n / mm_pkg::dim == n % mm_pkg::dim) ? 8'd1 : 8'd0;
        end
        load_matrix(mem_pkg::sel_b);
        run_engine("identity_run", 1'b0);
        check_c("identity_run", 1'b1);

        if (n_checks == n_reads) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_on_error($sformatf("only %0d of %0d host reads were compared",
                                    n_checks, n_reads));
        end
    end

endmodule

//--- tb.f
source/mm_pkg.sv
source/mem_pkg.sv
source/mux4_sram.sv
source/mm_sequencer.sv
source/mac_unit.sv
source/mem_port_arbiter.sv
source/mat_mult_top.sv
sim/tb_mat_mult.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP      = tb_mat_mult
FILELIST = tb.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# build and run, the exit status carries pass or fail
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
